//--- Makefile
TOP := vga_text_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+design
design/vga_text_pkg.sv
design/vga_timing.sv
design/char_buffer.sv
design/glyph_renderer.sv
design/vga_text_top.sv
tests/vga_text_tb.sv

//--- design/char_buffer.sv
// 80x30 text cell memory
// Single write port, registered read port

`default_nettype none

`include "vga_text_macros.svh"

module char_buffer import vga_text_pkg::*; (
  input  wire logic       clk_25M,
  // Host write port
  input  wire logic       wr_en,
  input  wire hchar_t     wr_col,
  input  wire vchar_t     wr_row,
  input  wire glyph_t     wr_glyph,
  input  wire color_idx_t wr_fg,
  input  wire color_idx_t wr_bg,
  // Read port from the timing generator
  input  wire hchar_t     read_hchar,
  input  wire vchar_t     read_vchar,
  output glyph_t          cell_glyph,
  output color_idx_t      cell_fg,
  output color_idx_t      cell_bg
);

  // Cell word is glyph, fg, bg
  logic [9:0]  mem [0:`TEXT_CELLS-1];
  logic [9:0]  rd_word;
  logic [11:0] wr_addr;
  logic [11:0] rd_addr;

  // Row-major addressing
  assign wr_addr = 12'(wr_row) * 12'(`TEXT_COLS) + 12'(wr_col);
  assign rd_addr = 12'(read_vchar) * 12'(`TEXT_COLS) + 12'(read_hchar);

  // Blank glyph on black everywhere at start
  initial begin
    for (int i = 0; i < `TEXT_CELLS; i++)
      mem[i] = '0;
  end

  // Same-cycle read of a written cell gets the old word
  always_ff @(posedge clk_25M) begin
    if (wr_en)
      mem[wr_addr] <= {wr_glyph, wr_fg, wr_bg};
    rd_word <= mem[rd_addr];
  end

  assign cell_glyph = rd_word[9:6];
  assign cell_fg    = rd_word[5:3];
  assign cell_bg    = rd_word[2:0];

  // Host must stay inside the grid
  wr_in_grid: assert property (@(posedge clk_25M)
    wr_en |-> (wr_col < 7'(`TEXT_COLS)) && (wr_row < 5'(`TEXT_ROWS)));

endmodule

`default_nettype wire

//--- design/glyph_renderer.sv
// Glyph renderer with built-in 16-symbol 8x8 font
// Pixel bit select and 3-bit palette expansion to 4-bit RGB

`default_nettype none

module glyph_renderer import vga_text_pkg::*; (
  input  wire logic       clk_25M,
  // Offsets inside the cell, one cycle ahead of the cell data
  input  wire logic [2:0] read_hoffset,
  input  wire logic [3:0] read_voffset,
  // Cell contents from the buffer
  input  wire glyph_t     cell_glyph,
  input  wire color_idx_t cell_fg,
  input  wire color_idx_t cell_bg,
  // Pixel colour
  output logic [3:0]      pixel_red,
  output logic [3:0]      pixel_green,
  output logic [3:0]      pixel_blue
);

  // ------------------------------
  // Font table
  // ------------------------------
  // Top row in the high byte, bit 7 of each row is the leftmost pixel
  localparam logic [63:0] FONT [16] = '{
    64'h0000000000000000,  // blank
    64'h3C666E7666663C00,  // 0
    64'h1838181818187E00,  // 1
    64'h3C66060C30607E00,  // 2
    64'h3C66061C06663C00,  // 3
    64'h0C1C3C6C7E0C0C00,  // 4
    64'h7E607C0606663C00,  // 5
    64'h3C607C6666663C00,  // 6
    64'h7E060C1830303000,  // 7
    64'h3C66663C66663C00,  // 8
    64'h3C66663E060C3800,  // 9
    64'h183C66667E666600,  // A
    64'h7C66667C66667C00,  // B
    64'h3C66606060663C00,  // C
    64'h786C6666666C7800,  // D
    64'h7E60607C60607E00   // E
  };

  logic [2:0]  hoff_q;
  logic [3:0]  voff_q;
  logic [2:0]  glyph_row;
  logic [63:0] glyph_bits;
  logic [7:0]  row_bits;
  logic        pixel_on;
  color_idx_t  sel_color;

  // Align offsets with the registered buffer read
  always_ff @(posedge clk_25M) begin
    hoff_q <= read_hoffset;
    voff_q <= read_voffset;
  end

  // ------------------------------
  // Pixel lookup
  // ------------------------------
  // 16 lines per cell, each font row shown twice
  assign glyph_row  = voff_q[3:1];
  assign glyph_bits = FONT[cell_glyph];
  // Row 0 sits in bits 63:56
  assign row_bits   = glyph_bits[{3'd7 - glyph_row, 3'b000} +: 8];
  assign pixel_on   = row_bits[3'd7 - hoff_q];

  // Foreground on set bits, background elsewhere
  assign sel_color = pixel_on ? cell_fg : cell_bg;

  // Palette bit to full-scale channel
  assign pixel_red   = {4{sel_color[2]}};
  assign pixel_green = {4{sel_color[1]}};
  assign pixel_blue  = {4{sel_color[0]}};

endmodule

`default_nettype wire

//--- design/vga_text_macros.svh
// VGA 640x480 timing constants and text grid dimensions
// Phase values are the last count of each phase

`ifndef VGA_TEXT_MACROS_SVH
`define VGA_TEXT_MACROS_SVH

// ------------------------------
// Horizontal timing, pixel clocks
// ------------------------------
`define VGA_H_ACTIVE 10'd639
`define VGA_H_FRONT  10'd15
`define VGA_H_PULSE  10'd95
`define VGA_H_BACK   10'd47

// ------------------------------
// Vertical timing, lines
// ------------------------------
`define VGA_V_ACTIVE 9'd479
`define VGA_V_FRONT  9'd9
`define VGA_V_PULSE  9'd1
`define VGA_V_BACK   9'd32

// ------------------------------
// Text grid, 8x16 pixel cells
// ------------------------------
`define TEXT_COLS  80
`define TEXT_ROWS  30
`define TEXT_CELLS (`TEXT_COLS * `TEXT_ROWS)

`endif

//--- design/vga_text_pkg.sv
// Shared types for the text-mode VGA subsystem
// Phase enum and cell field types

`default_nettype none

package vga_text_pkg;

  // Four phases of a line or a frame
  typedef enum logic [1:0] {
    PHASE_ACTIVE = 2'd0,
    PHASE_FRONT  = 2'd1,
    PHASE_PULSE  = 2'd2,
    PHASE_BACK   = 2'd3
  } vga_phase_e;

  // Font index, 16 symbols
  typedef logic [3:0] glyph_t;
  // Palette index, bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] color_idx_t;
  // Cell coordinates
  typedef logic [6:0] hchar_t;
  typedef logic [4:0] vchar_t;

endpackage

`default_nettype wire

//--- design/vga_text_top.sv
// Text-mode VGA top level
// Timing generator, cell buffer and glyph renderer

`default_nettype none

module vga_text_top import vga_text_pkg::*; (
  input  wire logic       clk_25M,
  input  wire logic       rst,
  // Host cell write
  input  wire logic       wr_en,
  input  wire hchar_t     wr_col,
  input  wire vchar_t     wr_row,
  input  wire glyph_t     wr_glyph,
  input  wire color_idx_t wr_fg,
  input  wire color_idx_t wr_bg,
  // VGA connector
  output logic [3:0]      vga_r,
  output logic [3:0]      vga_g,
  output logic [3:0]      vga_b,
  output logic            vga_hs,
  output logic            vga_vs,
  output logic            vga_blank_n
);

  // Read coordinates from the timing generator
  hchar_t     read_hchar;
  vchar_t     read_vchar;
  logic [2:0] read_hoffset;
  logic [3:0] read_voffset;
  // Registered cell contents
  glyph_t     cell_glyph;
  color_idx_t cell_fg;
  color_idx_t cell_bg;
  // Rendered pixel, one cycle behind the coordinates
  logic [3:0] pixel_red;
  logic [3:0] pixel_green;
  logic [3:0] pixel_blue;

  vga_timing u_timing (
    .clk_25M      (clk_25M),
    .rst          (rst),
    .pixel_red    (pixel_red),
    .pixel_green  (pixel_green),
    .pixel_blue   (pixel_blue),
    .read_hchar   (read_hchar),
    .read_vchar   (read_vchar),
    .read_hoffset (read_hoffset),
    .read_voffset (read_voffset),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .vga_hs       (vga_hs),
    .vga_vs       (vga_vs),
    .vga_blank_n  (vga_blank_n)
  );

  char_buffer u_buffer (
    .clk_25M    (clk_25M),
    .wr_en      (wr_en),
    .wr_col     (wr_col),
    .wr_row     (wr_row),
    .wr_glyph   (wr_glyph),
    .wr_fg      (wr_fg),
    .wr_bg      (wr_bg),
    .read_hchar (read_hchar),
    .read_vchar (read_vchar),
    .cell_glyph (cell_glyph),
    .cell_fg    (cell_fg),
    .cell_bg    (cell_bg)
  );

  glyph_renderer u_renderer (
    .clk_25M      (clk_25M),
    .read_hoffset (read_hoffset),
    .read_voffset (read_voffset),
    .cell_glyph   (cell_glyph),
    .cell_fg      (cell_fg),
    .cell_bg      (cell_bg),
    .pixel_red    (pixel_red),
    .pixel_green  (pixel_green),
    .pixel_blue   (pixel_blue)
  );

endmodule

`default_nettype wire

//--- design/vga_timing.sv
// VGA timing generator for 640x480 at 25 MHz
// Phase machines, sync, character read coordinates, colour gating

`default_nettype none

`include "vga_text_macros.svh"

module vga_timing import vga_text_pkg::*; (
  input  wire logic   clk_25M,
  input  wire logic   rst,
  // Pixel colour for the coordinates sent one cycle earlier
  input  wire logic [3:0] pixel_red,
  input  wire logic [3:0] pixel_green,
  input  wire logic [3:0] pixel_blue,
  // Character read coordinates
  output hchar_t      read_hchar,
  output vchar_t      read_vchar,
  output logic [2:0]  read_hoffset,
  output logic [3:0]  read_voffset,
  // VGA connector
  output logic [3:0]  vga_r,
  output logic [3:0]  vga_g,
  output logic [3:0]  vga_b,
  output logic        vga_hs,
  output logic        vga_vs,
  output logic        vga_blank_n
);

  // Phase order wraps back to active
  function automatic vga_phase_e next_phase(vga_phase_e p);
    case (p)
      PHASE_ACTIVE: next_phase = PHASE_FRONT;
      PHASE_FRONT:  next_phase = PHASE_PULSE;
      PHASE_PULSE:  next_phase = PHASE_BACK;
      default:      next_phase = PHASE_ACTIVE;
    endcase
  endfunction

  vga_phase_e h_state;
  vga_phase_e v_state;
  logic [9:0] h_counter;
  logic [8:0] v_counter;
  logic [9:0] h_last;
  logic [8:0] v_last;
  logic       h_end;
  logic       v_end;
  logic       line_done;
  logic       h_active;
  logic       v_active;
  logic       active_q;

  // ------------------------------
  // Phase end detection
  // ------------------------------
  always_comb begin
    case (h_state)
      PHASE_ACTIVE: h_last = `VGA_H_ACTIVE;
      PHASE_FRONT:  h_last = `VGA_H_FRONT;
      PHASE_PULSE:  h_last = `VGA_H_PULSE;
      default:      h_last = `VGA_H_BACK;
    endcase
    case (v_state)
      PHASE_ACTIVE: v_last = `VGA_V_ACTIVE;
      PHASE_FRONT:  v_last = `VGA_V_FRONT;
      PHASE_PULSE:  v_last = `VGA_V_PULSE;
      default:      v_last = `VGA_V_BACK;
    endcase
  end

  assign h_end = (h_counter == h_last);
  assign v_end = (v_counter == v_last);
  // Last cycle of back porch closes the line
  assign line_done = h_end && (h_state == PHASE_BACK);

  // ------------------------------
  // Counters and phase machines
  // ------------------------------
  always_ff @(posedge clk_25M) begin
    if (rst) begin
      h_counter <= '0;
      v_counter <= '0;
      h_state   <= PHASE_ACTIVE;
      v_state   <= PHASE_ACTIVE;
    end else begin
      // Counter restarts at every phase end
      h_counter <= h_end ? 10'd0 : h_counter + 10'd1;
      if (h_end)
        h_state <= next_phase(h_state);
      // Vertical side moves once per line
      if (line_done) begin
        v_counter <= v_end ? 9'd0 : v_counter + 9'd1;
        if (v_end)
          v_state <= next_phase(v_state);
      end
    end
  end

  // ------------------------------
  // Read coordinates
  // ------------------------------
  assign h_active = (h_state == PHASE_ACTIVE);
  assign v_active = (v_state == PHASE_ACTIVE);

  // Held at zero outside active area
  assign read_hchar   = h_active ? h_counter[9:3] : '0;
  assign read_hoffset = h_active ? h_counter[2:0] : '0;
  assign read_vchar   = v_active ? v_counter[8:4] : '0;
  assign read_voffset = v_active ? v_counter[3:0] : '0;

  // Sync and blank lag the counters by one cycle, same as pixel data
  always_ff @(posedge clk_25M) begin
    if (rst) begin
      vga_hs   <= 1'b1;
      vga_vs   <= 1'b1;
      active_q <= 1'b0;
    end else begin
      vga_hs   <= (h_state != PHASE_PULSE);
      vga_vs   <= (v_state != PHASE_PULSE);
      active_q <= h_active && v_active;
    end
  end

  assign vga_blank_n = active_q;
  // Colour forced black in blanking
  assign vga_r = active_q ? pixel_red   : 4'd0;
  assign vga_g = active_q ? pixel_green : 4'd0;
  assign vga_b = active_q ? pixel_blue  : 4'd0;

  // Sync low only for the registered pulse phase, never over shown pixels
  hs_in_pulse: assert property (@(posedge clk_25M) disable iff (rst)
    !vga_hs |-> $past(h_state) == PHASE_PULSE && !vga_blank_n);

  h_count_range: assert property (@(posedge clk_25M) disable iff (rst)
    h_counter <= `VGA_H_ACTIVE);

endmodule

`default_nettype wire

//--- tests/vga_text_stimulus.txt
# W col row glyph fg bg : cell write, decimal cell position, hex glyph and colours
# P x y r g b : expected pixel of the second frame, in scan order, hex channels
W 0 0 2 7 1
W 5 2 b 2 0
W 79 29 9 3 5
W 5 2 f 6 4
P 0 0 0 0 f
P 3 0 f f f
P 2 3 f f f
P 12 5 0 0 0
P 1 12 f f f
P 7 15 0 0 f
P 40 32 f 0 0
P 41 32 f f 0
P 43 38 f f 0
P 46 40 f 0 0
P 320 240 0 0 0
P 634 464 0 f f
P 639 466 f 0 f
P 633 479 f 0 f

//--- tests/vga_text_tb.sv
// Testbench for the text-mode VGA top level
// File-driven cell writes, per-cycle sync and blank model, pixel colour checks

`default_nettype none

module vga_text_tb import vga_text_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // 640x480 frame geometry, 800 clocks by 525 lines
  localparam int LINE_CYCLES  = 800;
  localparam int FRAME_CYCLES = 800 * 525;
  localparam int WAIT_LIMIT   = 900000;

  logic       clk_25M;
  logic       rst;
  logic       wr_en;
  hchar_t     wr_col;
  vchar_t     wr_row;
  glyph_t     wr_glyph;
  color_idx_t wr_fg;
  color_idx_t wr_bg;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;
  logic       vga_hs;
  logic       vga_vs;
  logic       vga_blank_n;

  // Scan position shown on the outputs, -1 until the first pixel
  int pos = -1;
  int sync_checks = 0;
  int sync_errors = 0;
  int pix_checks = 0;
  int pix_errors = 0;
  // Run lengths inside the current line and frame
  int hs_low = 0;
  int act_cnt = 0;
  int vs_low = 0;
  // Cell writes as {col, row, glyph, fg, bg}
  logic [21:0] wr_q[$];
  int pix_x[$];
  int pix_y[$];
  int pix_rgb[$];

  vga_text_top UUT (
    .clk_25M     (clk_25M),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_col      (wr_col),
    .wr_row      (wr_row),
    .wr_glyph    (wr_glyph),
    .wr_fg       (wr_fg),
    .wr_bg       (wr_bg),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
  );

  initial begin
    clk_25M = 1'b0;
    forever #20 clk_25M = ~clk_25M;
  end

  task automatic check_value(input string name, input int got, input int exp,
                             inout int checks, inout int errs);
    checks++;
    assert (got == exp) else begin
      $display("ERROR %0d ns %s: got %0h expected %0h", $time, name, got, exp);
      errs++;
    end
  endtask

  // First pixel shows one edge after rst is seen low
  always @(posedge clk_25M) begin
    if (rst)
      pos <= -1;
    else
      pos <= pos + 1;
  end

  // ------------------------------
  // Sync and blank model
  // ------------------------------
  always @(negedge clk_25M) begin
    int x;
    int y;
    if (pos >= 0) begin
      x = pos % LINE_CYCLES;
      y = (pos / LINE_CYCLES) % 525;
      // Pulse at 656..751 and lines 490..491
      check_value("vga_hs", int'(vga_hs), int'(!(x >= 656 && x < 752)),
                  sync_checks, sync_errors);
      check_value("vga_vs", int'(vga_vs), int'(!(y >= 490 && y < 492)),
                  sync_checks, sync_errors);
      check_value("vga_blank_n", int'(vga_blank_n), int'(x < 640 && y < 480),
                  sync_checks, sync_errors);
      if (!vga_blank_n)
        check_value("rgb in blanking", int'({vga_r, vga_g, vga_b}), 0,
                    sync_checks, sync_errors);
      hs_low  += int'(!vga_hs);
      act_cnt += int'(vga_blank_n);
      vs_low  += int'(!vga_vs);
      if (x == LINE_CYCLES - 1) begin
        check_value("hs low cycles per line", hs_low, 96, sync_checks, sync_errors);
        if (y < 480)
          check_value("blank_n high cycles per line", act_cnt, 640, sync_checks, sync_errors);
        hs_low  = 0;
        act_cnt = 0;
        if (y == 524) begin
          check_value("vs low cycles per frame", vs_low, 1600, sync_checks, sync_errors);
          vs_low = 0;
        end
      end
    end
  end

  // ------------------------------
  // Stimulus and pixel checks
  // ------------------------------
  initial begin
    int fd;
    int a, b, c, d, e;
    int guard;
    int target;
    logic [8*96-1:0] line_buf;
    bit timed_out;
    bit load_failed;
    timed_out   = 1'b0;
    load_failed = 1'b0;
    rst      = 1'b1;
    wr_en    = 1'b0;
    wr_col   = '0;
    wr_row   = '0;
    wr_glyph = '0;
    wr_fg    = '0;
    wr_bg    = '0;
    fd = $fopen("tests/vga_text_stimulus.txt", "r");
    if (fd == 0) begin
      load_failed = 1'b1;
      $display("Could not open tests/vga_text_stimulus.txt");
    end else begin
      // Comment lines match neither format and fall through
      while ($fgets(line_buf, fd) != 0) begin
        if ($sscanf(line_buf, "W %d %d %h %h %h", a, b, c, d, e) == 5)
          wr_q.push_back({7'(a), 5'(b), 4'(c), 3'(d), 3'(e)});
        else if ($sscanf(line_buf, "P %d %d %h %h %h", a, b, c, d, e) == 5) begin
          pix_x.push_back(a);
          pix_y.push_back(b);
          pix_rgb.push_back((c << 8) | (d << 4) | e);
        end
      end
      $fclose(fd);
    end
    if (!load_failed && pix_x.size() == 0) begin
      load_failed = 1'b1;
      $display("The stimulus file holds no expected pixels");
    end
    repeat (8) @(posedge clk_25M);
    rst <= 1'b0;
    // All writes land early in the first frame
    @(posedge clk_25M);
    foreach (wr_q[i]) begin
      wr_en <= 1'b1;
      {wr_col, wr_row, wr_glyph, wr_fg, wr_bg} <= wr_q[i];
      @(posedge clk_25M);
    end
    wr_en <= 1'b0;
    // Expected pixels are in scan order, all in the second frame
    foreach (pix_x[i]) begin
      if (!timed_out) begin
        target = FRAME_CYCLES + pix_y[i] * LINE_CYCLES + pix_x[i];
        guard = 0;
        while (pos != target && guard < WAIT_LIMIT) begin
          @(negedge clk_25M);
          guard++;
        end
        if (pos != target) begin
          timed_out = 1'b1;
          $display("Timed out waiting for pixel %0d,%0d of the second frame",
                   pix_x[i], pix_y[i]);
        end else
          check_value($sformatf("rgb at %0d,%0d", pix_x[i], pix_y[i]),
                      int'({vga_r, vga_g, vga_b}), pix_rgb[i], pix_checks, pix_errors);
      end
    end
    // Let the sync model see the whole second frame
    if (!timed_out) begin
      guard = 0;
      while (pos < 2 * FRAME_CYCLES && guard < WAIT_LIMIT) begin
        @(negedge clk_25M);
        guard++;
      end
      if (pos < 2 * FRAME_CYCLES) begin
        timed_out = 1'b1;
        $display("Timed out waiting for the end of the second frame");
      end
    end
    $display("Sync checks %0d errors %0d, pixel checks %0d errors %0d",
             sync_checks, sync_errors, pix_checks, pix_errors);
    if (timed_out || load_failed || sync_errors != 0 || pix_errors != 0)
      $display("CHECKS FAILED");
    else
      $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
